//--- hw/ctl_regs_pkg.sv
`default_nettype none

package ctl_regs_pkg;

    // bank geometry
    localparam int addr_w_default = 8;
    localparam int word_w = 16;

    // status and identification
    localparam logic [7:0] addr_ctl_flag      = 8'h00;
    localparam logic [7:0] addr_fpga_state    = 8'h01;
    localparam logic [7:0] addr_version_major = 8'h02;
    localparam logic [7:0] addr_version_minor = 8'h03;

    // settings words
    localparam logic [7:0] addr_mod_cycle            = 8'h10;
    localparam logic [7:0] addr_mod_freq_div_0       = 8'h11;
    localparam logic [7:0] addr_mod_freq_div_1       = 8'h12;
    localparam logic [7:0] addr_stm_mode             = 8'h20;
    localparam logic [7:0] addr_stm_cycle            = 8'h21;
    localparam logic [7:0] addr_stm_freq_div_0       = 8'h22;
    localparam logic [7:0] addr_stm_freq_div_1       = 8'h23;
    localparam logic [7:0] addr_silencer_mode        = 8'h30;
    localparam logic [7:0] addr_silencer_update_rate = 8'h31;
    localparam logic [7:0] addr_debug_output_idx     = 8'h40;

    // sync time words from the low half up
    localparam logic [7:0] addr_sync_time_0 = 8'h50;
    localparam logic [7:0] addr_sync_time_1 = 8'h51;
    localparam logic [7:0] addr_sync_time_2 = 8'h52;
    localparam logic [7:0] addr_sync_time_3 = 8'h53;

    // bits of the control-flag word
    localparam int ctl_flag_set_bit       = 0;
    localparam int ctl_flag_force_fan_bit = 4;
    localparam int ctl_flag_sync_bit      = 8;

    localparam logic [7:0] version_major = 8'h0a;
    localparam logic [7:0] version_minor = 8'h01;

endpackage

`default_nettype wire

//--- hw/settings_pkg.sv
`default_nettype none

package settings_pkg;

    // field widths
    localparam int mod_cycle_w = 15;
    localparam int stm_cycle_w = 16;
    localparam int freq_div_w  = 32;
    localparam int sync_time_w = 64;
    localparam int debug_idx_w = 8;

    // mode encodings
    localparam logic stm_mode_gain                        = 1'b0;
    localparam logic silencer_mode_fixed_completion_steps = 1'b1;

    // values held until the first settings load
    localparam logic [mod_cycle_w-1:0] mod_cycle_default    = 15'd1;
    localparam logic [freq_div_w-1:0]  mod_freq_div_default = 32'd5120;
    localparam logic                   stm_mode_default     = stm_mode_gain;
    localparam logic [stm_cycle_w-1:0] stm_cycle_default    = '0;
    localparam logic [freq_div_w-1:0]  stm_freq_div_default = '1;

    localparam logic        silencer_mode_default        = silencer_mode_fixed_completion_steps;
    localparam logic [15:0] silencer_update_rate_default = 16'd256;

    localparam logic [debug_idx_w-1:0] debug_output_idx_default = 8'hff;

endpackage

`default_nettype wire

//--- hw/ctl_bram.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_bram
    import ctl_regs_pkg::*;
#(
    parameter int addr_w = 8
) (
    input  wire               CLK,
    input  wire               host_we,
    input  wire  [addr_w-1:0] host_addr,
    input  wire  [word_w-1:0] host_din,
    output logic [word_w-1:0] host_dout,
    input  wire               ctl_we,
    input  wire  [addr_w-1:0] ctl_addr,
    input  wire  [word_w-1:0] ctl_din,
    output logic [word_w-1:0] ctl_dout
);

    localparam int depth = 2 ** addr_w;

    logic [word_w-1:0] mem [depth];

    logic [addr_w-1:0] host_addr_q;
    logic [addr_w-1:0] ctl_addr_q;

    // host port
    always @(posedge CLK) begin
        if (host_we) begin
            mem[host_addr] <= host_din;
        end
        host_addr_q <= host_addr;
        host_dout   <= mem[host_addr_q];
    end

    // controller port, same structure
    always @(posedge CLK) begin
        if (ctl_we) begin
            mem[ctl_addr] <= ctl_din;
        end
        ctl_addr_q <= ctl_addr;
        ctl_dout   <= mem[ctl_addr_q];
    end

endmodule

`default_nettype wire

//--- hw/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller
    import ctl_regs_pkg::*;
    import settings_pkg::*;
#(
    parameter int addr_w = addr_w_default
) (
    input  wire                       CLK,
    input  wire                       rst_n,
    input  wire                       thermo,
    input  wire  [word_w-1:0]         ctl_dout,
    output logic                      ctl_we,
    output logic [addr_w-1:0]         ctl_addr,
    output logic [word_w-1:0]         ctl_din,
    output logic                      update_settings,
    output logic                      force_fan,
    output logic [mod_cycle_w-1:0]    mod_cycle,
    output logic [freq_div_w/2-1:0]   mod_freq_div_0,
    output logic [freq_div_w/2-1:0]   mod_freq_div_1,
    output logic                      stm_mode,
    output logic [stm_cycle_w-1:0]    stm_cycle,
    output logic [freq_div_w/2-1:0]   stm_freq_div_0,
    output logic [freq_div_w/2-1:0]   stm_freq_div_1,
    output logic                      silencer_mode,
    output logic [15:0]               silencer_update_rate,
    output logic [debug_idx_w-1:0]    debug_output_idx,
    output logic                      sync_set,
    output logic [sync_time_w-1:0]    sync_time
);

    typedef enum logic [4:0] {
        init_ver_minor, init_ver_major, init_req_flag, init_wait_0, init_wait_1,
        wait_0, wait_1,
        ld_req_mod_cycle, ld_req_mod_fd_0, ld_req_mod_fd_1, ld_req_stm_mode,
        ld_req_stm_cycle, ld_req_stm_fd_0, ld_req_stm_fd_1, ld_req_sil_mode,
        ld_req_sil_rate, ld_req_debug, ld_rd_sil_mode, ld_rd_sil_rate,
        ld_rd_debug, ld_done,
        sy_req_0, sy_req_1, sy_req_2, sy_req_3, sy_rd_1, sy_rd_2, sy_rd_3, sy_done
    } state_t;

    state_t state;
    logic [word_w-1:0] ctl_flags;

    function automatic logic [addr_w-1:0] bank_addr(input logic [7:0] a);
        return addr_w'(a);
    endfunction

    assign force_fan = ctl_flags[ctl_flag_force_fan_bit];

    // each state issues one address and takes the data asked for three states back
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state                <= init_ver_minor;
            ctl_flags            <= '0;
            ctl_we               <= 1'b0;
            ctl_addr             <= '0;
            ctl_din              <= '0;
            update_settings      <= 1'b0;
            sync_set             <= 1'b0;
            mod_cycle            <= mod_cycle_default;
            mod_freq_div_0       <= mod_freq_div_default[freq_div_w/2-1:0];
            mod_freq_div_1       <= mod_freq_div_default[freq_div_w-1:freq_div_w/2];
            stm_mode             <= stm_mode_default;
            stm_cycle            <= stm_cycle_default;
            stm_freq_div_0       <= stm_freq_div_default[freq_div_w/2-1:0];
            stm_freq_div_1       <= stm_freq_div_default[freq_div_w-1:freq_div_w/2];
            silencer_mode        <= silencer_mode_default;
            silencer_update_rate <= silencer_update_rate_default;
            debug_output_idx     <= debug_output_idx_default;
            sync_time            <= '0;
        end else begin
            case (state)
                init_ver_minor: begin
                    ctl_we   <= 1'b1;
                    ctl_addr <= bank_addr(addr_version_minor);
                    ctl_din  <= word_w'(version_minor);
                    state    <= init_ver_major;
                end
                init_ver_major: begin
                    ctl_addr <= bank_addr(addr_version_major);
                    ctl_din  <= word_w'(version_major);
                    state    <= init_req_flag;
                end
                init_req_flag: begin
                    ctl_we   <= 1'b0;
                    ctl_addr <= bank_addr(addr_ctl_flag);
                    state    <= init_wait_0;
                end
                init_wait_0: state <= init_wait_1;
                init_wait_1: state <= wait_0;

                wait_0: begin
                    ctl_flags <= ctl_dout;
                    ctl_we    <= 1'b1;
                    ctl_addr  <= bank_addr(addr_fpga_state);
                    ctl_din   <= word_w'(thermo);
                    state     <= wait_1;
                end
                wait_1: begin
                    ctl_addr <= bank_addr(addr_ctl_flag);
                    // sync wins over a pending settings request
                    if (ctl_flags[ctl_flag_sync_bit]) begin
                        ctl_we  <= 1'b1;
                        ctl_din <= ctl_flags & ~(word_w'(1) << ctl_flag_sync_bit);
                        state   <= sy_req_0;
                    end else if (ctl_flags[ctl_flag_set_bit]) begin
                        ctl_we  <= 1'b1;
                        ctl_din <= ctl_flags & ~(word_w'(1) << ctl_flag_set_bit);
                        state   <= ld_req_mod_cycle;
                    end else begin
                        ctl_we <= 1'b0;
                        state  <= wait_0;
                    end
                end

                ld_req_mod_cycle: begin
                    ctl_we   <= 1'b0;
                    ctl_addr <= bank_addr(addr_mod_cycle);
                    state    <= ld_req_mod_fd_0;
                end
                ld_req_mod_fd_0: begin
                    ctl_addr <= bank_addr(addr_mod_freq_div_0);
                    state    <= ld_req_mod_fd_1;
                end
                ld_req_mod_fd_1: begin
                    ctl_addr <= bank_addr(addr_mod_freq_div_1);
                    state    <= ld_req_stm_mode;
                end
                ld_req_stm_mode: begin
                    ctl_addr  <= bank_addr(addr_stm_mode);
                    mod_cycle <= ctl_dout[mod_cycle_w-1:0];
                    state     <= ld_req_stm_cycle;
                end
                ld_req_stm_cycle: begin
                    ctl_addr       <= bank_addr(addr_stm_cycle);
                    mod_freq_div_0 <= ctl_dout;
                    state          <= ld_req_stm_fd_0;
                end
                ld_req_stm_fd_0: begin
                    ctl_addr       <= bank_addr(addr_stm_freq_div_0);
                    mod_freq_div_1 <= ctl_dout;
                    state          <= ld_req_stm_fd_1;
                end
                ld_req_stm_fd_1: begin
                    ctl_addr <= bank_addr(addr_stm_freq_div_1);
                    stm_mode <= ctl_dout[0];
                    state    <= ld_req_sil_mode;
                end
                ld_req_sil_mode: begin
                    ctl_addr  <= bank_addr(addr_silencer_mode);
                    stm_cycle <= ctl_dout[stm_cycle_w-1:0];
                    state     <= ld_req_sil_rate;
                end
                ld_req_sil_rate: begin
                    ctl_addr       <= bank_addr(addr_silencer_update_rate);
                    stm_freq_div_0 <= ctl_dout;
                    state          <= ld_req_debug;
                end
                ld_req_debug: begin
                    ctl_addr       <= bank_addr(addr_debug_output_idx);
                    stm_freq_div_1 <= ctl_dout;
                    state          <= ld_rd_sil_mode;
                end
                ld_rd_sil_mode: begin
                    // fresh flag word for the return to the poll loop
                    ctl_addr      <= bank_addr(addr_ctl_flag);
                    silencer_mode <= ctl_dout[0];
                    state         <= ld_rd_sil_rate;
                end
                ld_rd_sil_rate: begin
                    ctl_we               <= 1'b1;
                    ctl_addr             <= bank_addr(addr_fpga_state);
                    ctl_din              <= word_w'(thermo);
                    silencer_update_rate <= ctl_dout;
                    state                <= ld_rd_debug;
                end
                ld_rd_debug: begin
                    ctl_we           <= 1'b0;
                    ctl_addr         <= bank_addr(addr_ctl_flag);
                    debug_output_idx <= ctl_dout[debug_idx_w-1:0];
                    update_settings  <= 1'b1;
                    state            <= ld_done;
                end
                ld_done: begin
                    update_settings <= 1'b0;
                    ctl_flags       <= ctl_dout;
                    ctl_we          <= 1'b1;
                    ctl_addr        <= bank_addr(addr_fpga_state);
                    ctl_din         <= word_w'(thermo);
                    state           <= wait_1;
                end

                sy_req_0: begin
                    ctl_we   <= 1'b0;
                    ctl_addr <= bank_addr(addr_sync_time_0);
                    state    <= sy_req_1;
                end
                sy_req_1: begin
                    ctl_addr <= bank_addr(addr_sync_time_1);
                    state    <= sy_req_2;
                end
                sy_req_2: begin
                    ctl_addr <= bank_addr(addr_sync_time_2);
                    state    <= sy_req_3;
                end
                sy_req_3: begin
                    ctl_addr        <= bank_addr(addr_sync_time_3);
                    sync_time[15:0] <= ctl_dout;
                    state           <= sy_rd_1;
                end
                sy_rd_1: begin
                    ctl_addr         <= bank_addr(addr_ctl_flag);
                    sync_time[31:16] <= ctl_dout;
                    state            <= sy_rd_2;
                end
                sy_rd_2: begin
                    ctl_we           <= 1'b1;
                    ctl_addr         <= bank_addr(addr_fpga_state);
                    ctl_din          <= word_w'(thermo);
                    sync_time[47:32] <= ctl_dout;
                    state            <= sy_rd_3;
                end
                sy_rd_3: begin
                    ctl_we           <= 1'b0;
                    ctl_addr         <= bank_addr(addr_ctl_flag);
                    sync_time[63:48] <= ctl_dout;
                    sync_set         <= 1'b1;
                    state            <= sy_done;
                end
                sy_done: begin
                    sync_set  <= 1'b0;
                    ctl_flags <= ctl_dout;
                    ctl_we    <= 1'b1;
                    ctl_addr  <= bank_addr(addr_fpga_state);
                    ctl_din   <= word_w'(thermo);
                    state     <= wait_1;
                end

                default: state <= init_ver_minor;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sys_time.sv
`timescale 1ns/1ps
`default_nettype none

module sys_time
    import settings_pkg::*;
(
    input  wire                    CLK,
    input  wire                    rst_n,
    input  wire                    sync_set,
    input  wire  [sync_time_w-1:0] sync_time,
    output logic [sync_time_w-1:0] sys_time
);

    // free-running time base realigned by each sync request
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            sys_time <= '0;
        end else if (sync_set) begin
            sys_time <= sync_time;
        end else begin
            sys_time <= sys_time + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/ctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_top
    import ctl_regs_pkg::*;
    import settings_pkg::*;
#(
    parameter int addr_w = addr_w_default
) (
    input  wire                       CLK,
    input  wire                       rst_n,
    input  wire                       thermo,
    input  wire                       host_we,
    input  wire  [addr_w-1:0]         host_addr,
    input  wire  [word_w-1:0]         host_din,
    output logic [word_w-1:0]         host_dout,
    output logic [mod_cycle_w-1:0]    mod_cycle,
    output logic [freq_div_w/2-1:0]   mod_freq_div_0,
    output logic [freq_div_w/2-1:0]   mod_freq_div_1,
    output logic                      stm_mode,
    output logic [stm_cycle_w-1:0]    stm_cycle,
    output logic [freq_div_w/2-1:0]   stm_freq_div_0,
    output logic [freq_div_w/2-1:0]   stm_freq_div_1,
    output logic                      silencer_mode,
    output logic [15:0]               silencer_update_rate,
    output logic [debug_idx_w-1:0]    debug_output_idx,
    output logic                      update_settings,
    output logic                      sync_set,
    output logic                      force_fan,
    output logic [sync_time_w-1:0]    sys_time
);

    // controller side of the bank
    logic              ctl_we;
    logic [addr_w-1:0] ctl_addr;
    logic [word_w-1:0] ctl_din;
    logic [word_w-1:0] ctl_dout;

    logic [sync_time_w-1:0] sync_time;

    ctl_bram #(
        .addr_w (addr_w)
    ) ctl_bram_inst (
        .CLK       (CLK),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_dout (host_dout),
        .ctl_we    (ctl_we),
        .ctl_addr  (ctl_addr),
        .ctl_din   (ctl_din),
        .ctl_dout  (ctl_dout)
    );

    controller #(
        .addr_w (addr_w)
    ) controller_inst (
        .CLK                  (CLK),
        .rst_n                (rst_n),
        .thermo               (thermo),
        .ctl_dout             (ctl_dout),
        .ctl_we               (ctl_we),
        .ctl_addr             (ctl_addr),
        .ctl_din              (ctl_din),
        .update_settings      (update_settings),
        .force_fan            (force_fan),
        .mod_cycle            (mod_cycle),
        .mod_freq_div_0       (mod_freq_div_0),
        .mod_freq_div_1       (mod_freq_div_1),
        .stm_mode             (stm_mode),
        .stm_cycle            (stm_cycle),
        .stm_freq_div_0       (stm_freq_div_0),
        .stm_freq_div_1       (stm_freq_div_1),
        .silencer_mode        (silencer_mode),
        .silencer_update_rate (silencer_update_rate),
        .debug_output_idx     (debug_output_idx),
        .sync_set             (sync_set),
        .sync_time            (sync_time)
    );

    sys_time sys_time_inst (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .sync_set  (sync_set),
        .sync_time (sync_time),
        .sys_time  (sys_time)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ctl_top
    import ctl_regs_pkg::*;
    import settings_pkg::*;
;

    localparam int num_rows       = 6;
    localparam int pulse_limit    = 40;
    localparam int timeout_cycles = num_rows * 2 * 80 + 200;

    logic        CLK;
    logic        rst_n;
    logic        thermo;
    logic        host_we;
    logic [7:0]  host_addr;
    logic [15:0] host_din;

    wire  [15:0]            host_dout;
    wire  [mod_cycle_w-1:0] mod_cycle;
    wire  [15:0]            mod_freq_div_0;
    wire  [15:0]            mod_freq_div_1;
    wire                    stm_mode;
    wire  [stm_cycle_w-1:0] stm_cycle;
    wire  [15:0]            stm_freq_div_0;
    wire  [15:0]            stm_freq_div_1;
    wire                    silencer_mode;
    wire  [15:0]            silencer_update_rate;
    wire  [debug_idx_w-1:0] debug_output_idx;
    wire                    update_settings;
    wire                    sync_set;
    wire                    force_fan;
    wire  [sync_time_w-1:0] sys_time;

    // stimulus table whose rows double as expected values
    logic [mod_cycle_w-1:0] row_mod_cycle [num_rows];
    logic [freq_div_w-1:0]  row_mod_fd    [num_rows];
    logic                   row_stm_mode  [num_rows];
    logic [stm_cycle_w-1:0] row_stm_cycle [num_rows];
    logic [freq_div_w-1:0]  row_stm_fd    [num_rows];
    logic                   row_sil_mode  [num_rows];
    logic [15:0]            row_sil_rate  [num_rows];
    logic [debug_idx_w-1:0] row_debug     [num_rows];
    logic [sync_time_w-1:0] row_sync      [num_rows];

    logic [31:0] lfsr = 32'h7fe7_8a8f;
    int cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    bit fan_state = 1'b0;

    ctl_top #(
        .addr_w (addr_w_default)
    ) ctl_top_inst (
        .CLK                  (CLK),
        .rst_n                (rst_n),
        .thermo               (thermo),
        .host_we              (host_we),
        .host_addr            (host_addr),
        .host_din             (host_din),
        .host_dout            (host_dout),
        .mod_cycle            (mod_cycle),
        .mod_freq_div_0       (mod_freq_div_0),
        .mod_freq_div_1       (mod_freq_div_1),
        .stm_mode             (stm_mode),
        .stm_cycle            (stm_cycle),
        .stm_freq_div_0       (stm_freq_div_0),
        .stm_freq_div_1       (stm_freq_div_1),
        .silencer_mode        (silencer_mode),
        .silencer_update_rate (silencer_update_rate),
        .debug_output_idx     (debug_output_idx),
        .update_settings      (update_settings),
        .sync_set             (sync_set),
        .force_fan            (force_fan),
        .sys_time             (sys_time)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, a settings or sync pulse never came", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] fan_word();
        return 16'(fan_state) << ctl_flag_force_fan_bit;
    endfunction

    task automatic fill_table();
        for (int r = 0; r < num_rows; r++) begin
            row_mod_cycle[r] = mod_cycle_w'(next_bits(mod_cycle_w));
            row_mod_fd[r]    = freq_div_w'(next_bits(freq_div_w));
            row_stm_mode[r]  = next_bits(1) != 0;
            row_stm_cycle[r] = stm_cycle_w'(next_bits(stm_cycle_w));
            row_stm_fd[r]    = freq_div_w'(next_bits(freq_div_w));
            row_sil_mode[r]  = next_bits(1) != 0;
            row_sil_rate[r]  = 16'(next_bits(16));
            row_debug[r]     = debug_idx_w'(next_bits(debug_idx_w));
            row_sync[r]      = next_bits(sync_time_w);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // stored on the second edge
    task automatic write_word(input logic [7:0] a, input logic [15:0] d);
        @(posedge CLK);
        host_we   <= 1'b1;
        host_addr <= a;
        host_din  <= d;
        @(posedge CLK);
        host_we   <= 1'b0;
    endtask

    // one edge into the address register and one into the output register
    task automatic read_word(input logic [7:0] a, output logic [15:0] d);
        @(posedge CLK);
        host_we   <= 1'b0;
        host_addr <= a;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        d = host_dout;
    endtask

    task automatic wait_for_pulse(input bit want_sync, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < pulse_limit) begin
            @(negedge CLK);
            n++;
            seen = want_sync ? sync_set : update_settings;
        end
        if (!seen) begin
            $display("%s did not pulse within %0d cycles of the request",
                     want_sync ? "sync_set" : "update_settings", pulse_limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic run_settings_row(input int r);
        bit seen;
        logic [15:0] word;
        int errs_before;
        errs_before = errors;
        write_word(addr_mod_cycle, 16'(row_mod_cycle[r]));
        write_word(addr_mod_freq_div_0, row_mod_fd[r][15:0]);
        write_word(addr_mod_freq_div_1, row_mod_fd[r][31:16]);
        write_word(addr_stm_mode, 16'(row_stm_mode[r]));
        write_word(addr_stm_cycle, row_stm_cycle[r]);
        write_word(addr_stm_freq_div_0, row_stm_fd[r][15:0]);
        write_word(addr_stm_freq_div_1, row_stm_fd[r][31:16]);
        write_word(addr_silencer_mode, 16'(row_sil_mode[r]));
        write_word(addr_silencer_update_rate, row_sil_rate[r]);
        write_word(addr_debug_output_idx, 16'(row_debug[r]));
        write_word(addr_ctl_flag, fan_word() | (16'd1 << ctl_flag_set_bit));
        wait_for_pulse(1'b0, seen);
        if (seen) begin
            check_value("mod_cycle", mod_cycle, row_mod_cycle[r]);
            check_value("mod_freq_div", {mod_freq_div_1, mod_freq_div_0}, row_mod_fd[r]);
            check_value("stm_mode", stm_mode, row_stm_mode[r]);
            check_value("stm_cycle", stm_cycle, row_stm_cycle[r]);
            check_value("stm_freq_div", {stm_freq_div_1, stm_freq_div_0}, row_stm_fd[r]);
            check_value("silencer_mode", silencer_mode, row_sil_mode[r]);
            check_value("silencer_update_rate", silencer_update_rate, row_sil_rate[r]);
            check_value("debug_output_idx", debug_output_idx, row_debug[r]);
            // single-cycle pulse
            @(negedge CLK);
            check_value("update_settings", update_settings, 0);
        end
        read_word(addr_ctl_flag, word);
        check_value("ctl_flag", word, fan_word());
        report_test($sformatf("settings row %0d", r), errs_before);
    endtask

    task automatic run_sync_row(input int r);
        bit seen;
        logic [15:0] word;
        int errs_before;
        errs_before = errors;
        write_word(addr_sync_time_0, row_sync[r][15:0]);
        write_word(addr_sync_time_1, row_sync[r][31:16]);
        write_word(addr_sync_time_2, row_sync[r][47:32]);
        write_word(addr_sync_time_3, row_sync[r][63:48]);
        write_word(addr_ctl_flag, fan_word() | (16'd1 << ctl_flag_sync_bit));
        wait_for_pulse(1'b1, seen);
        if (seen) begin
            @(negedge CLK);
            check_value("sys_time", sys_time, row_sync[r]);
            check_value("sync_set", sync_set, 0);
        end
        read_word(addr_ctl_flag, word);
        check_value("ctl_flag", word, fan_word());
        report_test($sformatf("sync row %0d", r), errs_before);
    endtask

    task automatic set_fan(input bit on);
        int errs_before;
        errs_before = errors;
        fan_state = on;
        write_word(addr_ctl_flag, fan_word());
        repeat (20) @(posedge CLK);
        @(negedge CLK);
        check_value("force_fan", force_fan, on);
        report_test($sformatf("fan control %0d", on), errs_before);
    endtask

    initial begin
        logic [15:0] word;
        int errs_before;
        rst_n     = 1'b0;
        thermo    = 1'b0;
        host_we   = 1'b0;
        host_addr = '0;
        host_din  = '0;
        fill_table();

        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        errs_before = errors;
        check_value("mod_cycle", mod_cycle, mod_cycle_default);
        check_value("mod_freq_div", {mod_freq_div_1, mod_freq_div_0}, mod_freq_div_default);
        check_value("stm_mode", stm_mode, stm_mode_default);
        check_value("stm_cycle", stm_cycle, stm_cycle_default);
        check_value("stm_freq_div", {stm_freq_div_1, stm_freq_div_0}, stm_freq_div_default);
        check_value("silencer_mode", silencer_mode, silencer_mode_default);
        check_value("silencer_update_rate", silencer_update_rate,
                    silencer_update_rate_default);
        check_value("debug_output_idx", debug_output_idx, debug_output_idx_default);
        check_value("update_settings", update_settings, 0);
        check_value("sync_set", sync_set, 0);
        report_test("reset defaults", errs_before);

        // version words land in the first cycles after reset
        repeat (4) @(posedge CLK);
        errs_before = errors;
        read_word(addr_version_major, word);
        check_value("version_major", word, 16'(version_major));
        read_word(addr_version_minor, word);
        check_value("version_minor", word, 16'(version_minor));
        report_test("version words", errs_before);

        errs_before = errors;
        @(posedge CLK);
        thermo <= 1'b1;
        repeat (20) @(posedge CLK);
        read_word(addr_fpga_state, word);
        check_value("fpga_state", word, 16'h0001);
        @(posedge CLK);
        thermo <= 1'b0;
        repeat (20) @(posedge CLK);
        read_word(addr_fpga_state, word);
        check_value("fpga_state", word, 16'h0000);
        report_test("thermo status", errs_before);

        set_fan(1'b1);
        for (int r = 0; r < num_rows; r++) begin
            run_settings_row(r);
            run_sync_row(r);
        end
        set_fan(1'b0);

        $display("tests run %0d, failing tests %0d, checks %0d, check errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/ctl_regs_pkg.sv
hw/settings_pkg.sv
hw/ctl_bram.sv
hw/controller.sv
hw/sys_time.sv
hw/ctl_top.sv
testbench/tb_ctl_top.sv

//--- Bender.yml
package:
  name: ctl_top

sources:
  - hw/ctl_regs_pkg.sv
  - hw/settings_pkg.sv
  - hw/ctl_bram.sv
  - hw/controller.sv
  - hw/sys_time.sv
  - hw/ctl_top.sv
  - target: test
    files:
      - testbench/tb_ctl_top.sv
